//--- common/memPkg.sv
// memory subsystem package: address union, page and register constants, ROM contents
package memPkg;

	// one CPU address word, read either as a RAM location or as an I/O register
	typedef union packed {
		struct packed {
			logic [1:0]  bank;	// top two bits pick the RAM bank
			logic [13:0] offset;	// word within the bank
		} ram;
		struct packed {
			logic [7:0] page;	// 256-word page of the map
			logic [3:0] sel;	// peripheral within an I/O page
			logic [3:0] regIdx;	// register within the peripheral
		} io;
	} memAddr_t;

	// address map pages
	localparam logic [7:0] ROM_PAGE  = 8'h00;	// boot ROM, 0x0000..0x00ff
	localparam logic [7:0] GPIO_PAGE = 8'h01;
	localparam logic [7:0] PWM_PAGE  = 8'h01;
	localparam logic [7:0] HOLE_LAST = 8'h0F;	// last page of the I/O area

	// peripheral select within an I/O page
	localparam logic [3:0] GPIO_SEL = 4'h1;	// 0x011x
	localparam logic [3:0] PWM_SEL  = 4'h2;	// 0x012x

	// GPIO registers
	localparam logic [3:0] GPIO_OUT_REG = 4'h0;	// output latch
	localparam logic [3:0] GPIO_IN_REG  = 4'h1;	// synchronized input pins

	// PWM registers, one duty per LED
	localparam logic [3:0] PWM_DUTY0 = 4'h0;
	localparam logic [3:0] PWM_DUTY1 = 4'h1;
	localparam logic [3:0] PWM_DUTY2 = 4'h2;

	// boot ROM image, a recognizable pattern with no two words alike
	function automatic logic [15:0] romWord(input logic [7:0] romAddr);
		logic [7:0] upper;
		upper = romAddr ^ 8'hA5;
		return {upper, romAddr};
	endfunction

endpackage

//--- memoryController/memoryController.sv
// memory controller: address decode, write strobe steering, registered read data mux
module memoryController #(
	parameter int BITS = 16
) (
	input  logic             CLK,
	input  logic             RSTb,
	input  memPkg::memAddr_t ADDRESS,
	input  logic             memWR,		// write strobe, one cycle
	input  logic             memRD,		// all reads are synchronous, kept for the CPU port
	input  logic [BITS-1:0]  romData,
	input  logic [BITS-1:0]  ramData0,
	input  logic [BITS-1:0]  ramData1,
	input  logic [BITS-1:0]  ramData2,
	input  logic [BITS-1:0]  ramData3,
	input  logic [BITS-1:0]  gpioData,
	input  logic [BITS-1:0]  pwmData,
	output logic [BITS-1:0]  DATA_OUT,
	output logic [3:0]       ramWr,
	output logic             gpioWr,
	output logic             pwmWr
);
	import memPkg::*;

	localparam logic [2:0] TGT_ROM  = 3'd0;
	localparam logic [2:0] TGT_RAM  = 3'd1;
	localparam logic [2:0] TGT_GPIO = 3'd2;
	localparam logic [2:0] TGT_PWM  = 3'd3;
	localparam logic [2:0] TGT_HOLE = 3'd4;

	memAddr_t   addrQ;		// address of the read in flight
	logic [2:0] wrTarget;
	logic [2:0] rdTarget;

	// the low pages are I/O, everything above them is RAM
	function automatic logic [2:0] targetOf(input memAddr_t a);
		if (a.io.page == ROM_PAGE)
			return TGT_ROM;
		if (a.io.page <= HOLE_LAST) begin
			if (a.io.page == GPIO_PAGE && a.io.sel == GPIO_SEL)
				return TGT_GPIO;
			if (a.io.page == PWM_PAGE && a.io.sel == PWM_SEL)
				return TGT_PWM;
			return TGT_HOLE;	// uart, spi, audio and gfx pages land here
		end
		return TGT_RAM;
	endfunction

	assign wrTarget = targetOf(ADDRESS);
	assign rdTarget = targetOf(addrQ);

	always_comb begin
		ramWr  = 4'b0000;
		gpioWr = 1'b0;
		pwmWr  = 1'b0;
		case (wrTarget)
			TGT_RAM:  ramWr[ADDRESS.ram.bank] = memWR;
			TGT_GPIO: gpioWr = memWR;
			TGT_PWM:  pwmWr = memWR;
			default:  ;	// ROM and hole drop writes
		endcase
	end

	// every target answers one cycle late, so the mux follows the registered address
	always_ff @(posedge CLK) begin
		if (!RSTb)
			addrQ <= '0;	// ROM word 0 after reset
		else
			addrQ <= ADDRESS;
	end

	always_comb begin
		DATA_OUT = '0;	// hole reads zero
		case (rdTarget)
			TGT_ROM: DATA_OUT = romData;
			TGT_RAM: begin
				case (addrQ.ram.bank)
					2'd0: DATA_OUT = ramData0;
					2'd1: DATA_OUT = ramData1;
					2'd2: DATA_OUT = ramData2;
					2'd3: DATA_OUT = ramData3;
				endcase
			end
			TGT_GPIO: DATA_OUT = gpioData;
			TGT_PWM:  DATA_OUT = pwmData;
			default:  ;
		endcase
	end

	// at most one target is written per cycle
	strobeOneHot: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0({ramWr, gpioWr, pwmWr}))
		else $error("more than one write strobe active");

	// a strobe only ever comes from a CPU write
	strobeNeedsWr: assert property (@(posedge CLK) disable iff (!RSTb)
		(|{ramWr, gpioWr, pwmWr}) |-> memWR)
		else $error("write strobe without memWR");

endmodule

//--- memoryController/bootRom.sv
// boot ROM: 256 words with registered read, contents from the package
module bootRom #(
	parameter int BITS = 16
) (
	input  logic            CLK,
	input  logic [7:0]      addr,
	output logic [BITS-1:0] data
);
	import memPkg::*;

	logic [BITS-1:0] romArray [256];

	// image is built at elaboration
	always_comb begin
		for (int i = 0; i < 256; i++) begin
			romArray[i] = BITS'(romWord(i[7:0]));
		end
	end

	always_ff @(posedge CLK) begin
		data <= romArray[addr];	// one cycle latency
	end

endmodule

//--- memoryController/ramBank.sv
// RAM bank: single port, write-first, synchronous read
module ramBank #(
	parameter int BITS              = 16,
	parameter int BANK_ADDRESS_BITS = 14
) (
	input  logic                         CLK,
	input  logic [BANK_ADDRESS_BITS-1:0] addr,
	input  logic [BITS-1:0]              wrData,
	input  logic                         wr,
	output logic [BITS-1:0]              rdData
);

	localparam int DEPTH = 2 ** BANK_ADDRESS_BITS;

	logic [BITS-1:0] mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[addr] <= wrData;
			rdData    <= wrData;	// write-first
		end else begin
			rdData <= mem[addr];
		end
	end

	// a write with an unknown address would corrupt an unknown word
	wrAddrKnown: assert property (@(posedge CLK)
		wr |-> !$isunknown(addr))
		else $error("RAM write with unknown address");

endmodule

//--- source/gpioPort.sv
// GPIO port: output latch, input synchronizer, registered register reads
module gpioPort #(
	parameter int BITS = 16
) (
	input  logic            CLK,
	input  logic            RSTb,
	input  logic [3:0]      regIdx,
	input  logic [BITS-1:0] wrData,
	input  logic            wr,
	input  logic [5:0]      pinsIn,
	output logic [BITS-1:0] rdData,
	output logic [3:0]      pinsOut
);
	import memPkg::*;

	logic [5:0] pinsMeta;	// first sync stage
	logic [5:0] pinsSync;	// safe to read

	// output latch
	always_ff @(posedge CLK) begin
		if (!RSTb)
			pinsOut <= 4'b0000;
		else if (wr && regIdx == GPIO_OUT_REG)
			pinsOut <= wrData[3:0];
	end

	// pins are asynchronous to CLK
	always_ff @(posedge CLK) begin
		pinsMeta <= pinsIn;
		pinsSync <= pinsMeta;
	end

	// pin change reaches rdData on the third edge
	always_ff @(posedge CLK) begin
		case (regIdx)
			GPIO_OUT_REG: rdData <= BITS'(pinsOut);
			GPIO_IN_REG:  rdData <= BITS'(pinsSync);
			default:      rdData <= '0;	// unused registers
		endcase
	end

endmodule

//--- source/pwmLed.sv
// PWM LED driver: three duty registers, free-running counter, registered outputs
module pwmLed #(
	parameter int BITS     = 16,
	parameter int PWM_BITS = 8
) (
	input  logic            CLK,
	input  logic            RSTb,
	input  logic [3:0]      regIdx,
	input  logic [BITS-1:0] wrData,
	input  logic            wr,
	output logic [BITS-1:0] rdData,
	output logic [2:0]      leds
);
	import memPkg::*;

	logic [PWM_BITS-1:0] counter;	// one period is 2**PWM_BITS cycles
	logic [PWM_BITS-1:0] duty [3];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			duty[0] <= '0;
			duty[1] <= '0;
			duty[2] <= '0;
		end else if (wr) begin
			case (regIdx)
				PWM_DUTY0: duty[0] <= wrData[PWM_BITS-1:0];
				PWM_DUTY1: duty[1] <= wrData[PWM_BITS-1:0];
				PWM_DUTY2: duty[2] <= wrData[PWM_BITS-1:0];
				default:   ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			counter <= '0;
		else
			counter <= counter + 1'b1;	// wraps
	end

	// each counter value occurs once per period, so duty d gives d high cycles
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			leds <= 3'b000;
		end else begin
			for (int i = 0; i < 3; i++) begin
				leds[i] <= counter < duty[i];
			end
		end
	end

	always_ff @(posedge CLK) begin
		case (regIdx)
			PWM_DUTY0: rdData <= BITS'(duty[0]);
			PWM_DUTY1: rdData <= BITS'(duty[1]);
			PWM_DUTY2: rdData <= BITS'(duty[2]);
			default:   rdData <= '0;
		endcase
	end

endmodule

//--- source/socTop.sv
// SoC top: memory controller, boot ROM, four RAM banks, GPIO and PWM LEDs
module socTop #(
	parameter int BITS              = 16,
	parameter int BANK_ADDRESS_BITS = 14,
	parameter int PWM_BITS          = 8
) (
	input  logic             CLK,
	input  logic             RSTb,
	input  memPkg::memAddr_t ADDRESS,
	input  logic [BITS-1:0]  DATA_IN,
	input  logic             memWR,
	input  logic             memRD,
	input  logic [5:0]       INPUT_PINS,
	output logic [BITS-1:0]  DATA_OUT,
	output logic [10:0]      PINS
);

	logic [BITS-1:0] romData;
	logic [BITS-1:0] ramData [4];
	logic [BITS-1:0] gpioData;
	logic [BITS-1:0] pwmData;
	logic [3:0]      ramWr;
	logic            gpioWr;
	logic            pwmWr;

	memoryController #(.BITS(BITS)) memoryController_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.memWR(memWR),
		.memRD(memRD),
		.romData(romData),
		.ramData0(ramData[0]),
		.ramData1(ramData[1]),
		.ramData2(ramData[2]),
		.ramData3(ramData[3]),
		.gpioData(gpioData),
		.pwmData(pwmData),
		.DATA_OUT(DATA_OUT),
		.ramWr(ramWr),
		.gpioWr(gpioWr),
		.pwmWr(pwmWr)
	);

	bootRom #(.BITS(BITS)) bootRom_i (
		.CLK(CLK),
		.addr(ADDRESS.ram.offset[7:0]),
		.data(romData)
	);

	// one bank per quarter of the address space
	for (genvar b = 0; b < 4; b++) begin : bankGen
		ramBank #(.BITS(BITS), .BANK_ADDRESS_BITS(BANK_ADDRESS_BITS)) ramBank_i (
			.CLK(CLK),
			.addr(ADDRESS.ram.offset[BANK_ADDRESS_BITS-1:0]),
			.wrData(DATA_IN),
			.wr(ramWr[b]),
			.rdData(ramData[b])
		);
	end

	gpioPort #(.BITS(BITS)) gpioPort_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.regIdx(ADDRESS.io.regIdx),
		.wrData(DATA_IN),
		.wr(gpioWr),
		.pinsIn(INPUT_PINS),
		.rdData(gpioData),
		.pinsOut(PINS[3:0])	// gpio outputs
	);

	pwmLed #(.BITS(BITS), .PWM_BITS(PWM_BITS)) pwmLed_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.regIdx(ADDRESS.io.regIdx),
		.wrData(DATA_IN),
		.wr(pwmWr),
		.rdData(pwmData),
		.leds(PINS[10:8])	// LED channels
	);

	assign PINS[7:4] = 4'b0000;	// spi flash pins, not fitted

endmodule

//--- sim/socChecks.svh
// testbench helpers: typed compares, bus read and write cycles, guarded GPIO input wait
`ifndef SOC_CHECKS_SVH
`define SOC_CHECKS_SVH

	localparam int INPUT_LATENCY = 3;	// synchronizer plus registered read

	task automatic checkWord(input string name, input logic [BITS-1:0] got,
		input logic [BITS-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic checkPins(input string name, input logic [10:0] got, input logic [10:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	// bus cycles start and end just after a falling edge
	task automatic busWrite(input memAddr_t a, input logic [BITS-1:0] d);
		ADDRESS = a;
		DATA_IN = d;
		memWR   = 1'b1;
		@(posedge CLK);
		@(negedge CLK);
		memWR = 1'b0;
	endtask

	task automatic busRead(input memAddr_t a, input logic [BITS-1:0] exp);
		ADDRESS = a;
		memRD   = 1'b1;
		@(posedge CLK);	// address taken here
		@(negedge CLK);	// data settled
		memRD = 1'b0;
		checkWord($sformatf("DATA_OUT at 0x%h", a), DATA_OUT, exp);
	endtask

	// keeps reading the input register until the pins show up
	task automatic waitInputSeen(input memAddr_t a, input logic [BITS-1:0] exp);
		int waited;
		waited  = 0;
		ADDRESS = a;
		memRD   = 1'b1;
		do begin
			@(posedge CLK);
			@(negedge CLK);
			waited++;
		end while (DATA_OUT !== exp && waited < INPUT_LATENCY);
		memRD = 1'b0;
		if (DATA_OUT !== exp) begin
			$display("GPIO input value 0x%h was not read back within %0d cycles",
				exp, INPUT_LATENCY);
			stopOnFailure();
		end
	endtask

`endif

//--- sim/socTopTb.sv
// SoC testbench: clock, reset, stimulus table with run loop, PWM duty count
module socTopTb;
	import memPkg::*;

	localparam int BITS              = 16;
	localparam int BANK_ADDRESS_BITS = 14;
	localparam int PWM_BITS          = 8;
	localparam int PWM_PERIOD        = 2 ** PWM_BITS;

	typedef enum {OP_WRITE, OP_READ, OP_PINS, OP_INPUT} stepOp_t;

	typedef struct {
		stepOp_t         op;
		memAddr_t        addr;
		logic [BITS-1:0] data;
		logic [BITS-1:0] expVal;
	} step_t;

	logic            CLK;
	logic            RSTb;
	memAddr_t        ADDRESS;
	logic [BITS-1:0] DATA_IN;
	logic            memWR;
	logic            memRD;
	logic [5:0]      INPUT_PINS;
	logic [BITS-1:0] DATA_OUT;
	logic [10:0]     PINS;

	step_t      steps[$];
	logic [7:0] duty [3];	// duties the LEDs should run with

	socTop #(.BITS(BITS), .BANK_ADDRESS_BITS(BANK_ADDRESS_BITS), .PWM_BITS(PWM_BITS)) socTop_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.memWR(memWR),
		.memRD(memRD),
		.INPUT_PINS(INPUT_PINS),
		.DATA_OUT(DATA_OUT),
		.PINS(PINS)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	task automatic stopOnFailure();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	`include "socChecks.svh"

	// upper byte is the address xor A5, lower byte the address
	function automatic logic [BITS-1:0] expectedRom(input logic [7:0] a);
		return BITS'({a ^ 8'hA5, a});
	endfunction

	function automatic memAddr_t ramAddr(input logic [1:0] bank, input logic [13:0] offset);
		memAddr_t a;
		a.ram.bank   = bank;
		a.ram.offset = offset;
		return a;
	endfunction

	function automatic memAddr_t ioAddr(input logic [7:0] page, input logic [3:0] sel,
		input logic [3:0] r);
		memAddr_t a;
		a.io.page   = page;
		a.io.sel    = sel;
		a.io.regIdx = r;
		return a;
	endfunction

	function automatic void pushStep(input stepOp_t op, input memAddr_t a,
		input logic [BITS-1:0] d, input logic [BITS-1:0] e);
		steps.push_back('{op, a, d, e});
	endfunction

	function automatic void buildTable();
		logic [7:0]      romA;
		logic [13:0]     common;
		logic [13:0]     offset;
		logic [BITS-1:0] word [4];
		logic [BITS-1:0] w;
		logic [BITS-1:0] gpioWord;
		logic [5:0]      pinVal;
		logic [15:0]     holes [6];
		for (int i = 0; i < 6; i++) begin
			romA = 8'($urandom);
			pushStep(OP_READ, ramAddr(2'd0, 14'(romA)), '0, expectedRom(romA));
		end
		romA = 8'($urandom);
		pushStep(OP_WRITE, ramAddr(2'd0, 14'(romA)), BITS'($urandom), '0);	// dropped
		pushStep(OP_READ, ramAddr(2'd0, 14'(romA)), '0, expectedRom(romA));
		common = 14'($urandom) | 14'h1000;	// clear of the I/O pages in bank 0
		for (int b = 0; b < 4; b++) begin
			word[b] = BITS'($urandom);
			pushStep(OP_WRITE, ramAddr(2'(b), common), word[b], '0);
		end
		for (int b = 0; b < 4; b++)
			pushStep(OP_READ, ramAddr(2'(b), common), '0, word[b]);
		for (int b = 0; b < 4; b++) begin
			offset = 14'($urandom);
			if (b == 0)
				offset = offset | 14'h1000;
			if (offset == common)
				offset = offset ^ 14'h0001;
			w = BITS'($urandom);
			pushStep(OP_WRITE, ramAddr(2'(b), offset), w, '0);
			pushStep(OP_READ, ramAddr(2'(b), offset), '0, w);
		end
		gpioWord = BITS'($urandom);
		pushStep(OP_WRITE, ioAddr(GPIO_PAGE, GPIO_SEL, GPIO_OUT_REG), gpioWord, '0);
		pushStep(OP_PINS, '0, '0, BITS'(gpioWord[3:0]));	// LEDs still dark
		pushStep(OP_READ, ioAddr(GPIO_PAGE, GPIO_SEL, GPIO_OUT_REG), '0, BITS'(gpioWord[3:0]));
		duty[0] = 8'h00;
		duty[1] = 8'($urandom_range(254, 1));
		duty[2] = 8'hFF;
		for (int i = 0; i < 3; i++) begin
			pushStep(OP_WRITE, ioAddr(PWM_PAGE, PWM_SEL, 4'(i)), BITS'(duty[i]), '0);
			pushStep(OP_READ, ioAddr(PWM_PAGE, PWM_SEL, 4'(i)), '0, BITS'(duty[i]));
		end
		holes = '{16'h0100, 16'h0130, 16'h0F10, 16'h0F20, 16'h0FFF,
			16'($urandom_range(16'h0FFF, 16'h0130))};
		foreach (holes[i]) begin
			pushStep(OP_WRITE, memAddr_t'(holes[i]), BITS'($urandom), '0);
			pushStep(OP_READ, memAddr_t'(holes[i]), '0, '0);
		end
		// nothing above may have moved
		for (int b = 0; b < 4; b++)
			pushStep(OP_READ, ramAddr(2'(b), common), '0, word[b]);
		pushStep(OP_READ, ioAddr(GPIO_PAGE, GPIO_SEL, GPIO_OUT_REG), '0, BITS'(gpioWord[3:0]));
		for (int i = 0; i < 3; i++)
			pushStep(OP_READ, ioAddr(PWM_PAGE, PWM_SEL, 4'(i)), '0, BITS'(duty[i]));
		pinVal = 6'($urandom_range(63, 1));	// differs from the idle pins
		pushStep(OP_INPUT, ioAddr(GPIO_PAGE, GPIO_SEL, GPIO_IN_REG), BITS'(pinVal), BITS'(pinVal));
		pinVal = ~pinVal;	// every pin toggles
		pushStep(OP_INPUT, ioAddr(GPIO_PAGE, GPIO_SEL, GPIO_IN_REG), BITS'(pinVal), BITS'(pinVal));
	endfunction

	task automatic runStep(input step_t s);
		case (s.op)
			OP_WRITE: busWrite(s.addr, s.data);
			OP_READ:  busRead(s.addr, s.expVal);
			OP_PINS:  checkPins("PINS", PINS, s.expVal[10:0]);
			OP_INPUT: begin
				INPUT_PINS = s.data[5:0];
				waitInputSeen(s.addr, s.expVal);
			end
		endcase
	endtask

	// one full counter period, sampled between edges
	task automatic checkLedDuty();
		int highCount [3];
		highCount = '{0, 0, 0};
		for (int c = 0; c < PWM_PERIOD; c++) begin
			@(negedge CLK);
			for (int i = 0; i < 3; i++)
				if (PINS[8+i])
					highCount[i]++;
		end
		for (int i = 0; i < 3; i++)
			checkCount($sformatf("PINS[%0d] high cycles", 8 + i), highCount[i], int'(duty[i]));
	endtask

	initial begin
		RSTb       = 1'b0;
		ADDRESS    = '0;
		DATA_IN    = '0;
		memWR      = 1'b0;
		memRD      = 1'b0;
		INPUT_PINS = 6'b000000;
		void'($urandom(45191));
		buildTable();
		repeat (4) @(negedge CLK);
		RSTb = 1'b1;
		checkWord("DATA_OUT after reset", DATA_OUT, expectedRom(8'h00));
		checkPins("PINS after reset", PINS, 11'h000);
		foreach (steps[i])
			runStep(steps[i]);
		checkLedDuty();
		$display("Test passed");
		$finish;
	end

endmodule

//--- project.f
+incdir+sim
common/memPkg.sv
memoryController/memoryController.sv
memoryController/bootRom.sv
memoryController/ramBank.sv
source/gpioPort.sv
source/pwmLed.sv
source/socTop.sv
sim/socTopTb.sv
